//--- src/ww_pkg.sv
package ww_pkg;

	localparam int WORD_W = 16;
	localparam int ADDR_W = 11;
	localparam int OP_W = 5;
	localparam int TP_DIV = 4;		// Clocks per time pulse
	localparam int DIV_W = $clog2(TP_DIV);
	localparam int FF_BASE = 'o3740;
	localparam int FF_WORDS = 5;
	localparam int FF_IDX_W = $clog2(FF_WORDS);
	localparam int TS_BASE = 'o3745;
	localparam int TS_WORDS = 27;
	localparam int TS_IDX_W = $clog2(TS_WORDS);
	localparam int CTRL_ADDR = 0;

	typedef logic [WORD_W-1:0] word_t;	// Sign in the MSB as old bit 0
	typedef logic [ADDR_W-1:0] addr_t;

	typedef enum logic [OP_W-1:0] {
		OP_TS = 5'o10,
		OP_CP = 5'o16,
		OP_SP = 5'o17,
		OP_CA = 5'o20,
		OP_AD = 5'o22,
		OP_SU = 5'o23
	} opcode_e;

	typedef struct packed {
		opcode_e op;
		addr_t addr;
	} instr_t;

	typedef enum logic [2:0] {TP1, TP2, TP3, TP4, TP5, TP6, TP7, TP8} tp_e;

	typedef struct packed {
		logic pr_load;
		logic pc_inc;
		logic ar_load;
		logic ac_clear;
		logic ac_add;
		logic ac_sub;
		logic st_write;
		logic jump;
		logic addr_sel_pc;	// Level, not a pulse
	} ctl_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		addr_t adr;
		word_t dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		word_t dat;
	} wb_rsp_t;

	typedef struct packed {
		logic run;
		addr_t start_pc;
	} panel_t;

	typedef struct packed {
		logic en;
		addr_t addr;
		word_t dat;
	} host_wr_t;

	typedef struct packed {
		logic running;
		addr_t pc;
		word_t ac;
	} status_t;

	function automatic logic is_ff_addr(addr_t a);
		return (a >= addr_t'(FF_BASE)) && (a < addr_t'(FF_BASE + FF_WORDS));
	endfunction

	// Switch words reach the top of the address space
	function automatic logic is_ts_addr(addr_t a);
		return (a >= addr_t'(TS_BASE)) && (int'(a) < TS_BASE + TS_WORDS);
	endfunction

	function automatic logic [FF_IDX_W-1:0] ff_index(addr_t a);
		return FF_IDX_W'(a - addr_t'(FF_BASE));
	endfunction

	function automatic logic [TS_IDX_W-1:0] ts_index(addr_t a);
		return TS_IDX_W'(a - addr_t'(TS_BASE));
	endfunction

endpackage

//--- src/ww_switch_regs.sv
`timescale 1ns/100ps

module ww_switch_regs import ww_pkg::*; (
	input logic clk,
	input logic reset,
	input wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	output panel_t panel,
	output host_wr_t host_wr,
	input addr_t ts_addr,
	output word_t ts_word,
	input word_t ff_rdata
);

	localparam int PANEL_PAD = WORD_W - $bits(panel_t);

	word_t ts_mem [TS_WORDS];	// Toggle-switch words
	logic ack;
	logic access;
	logic is_ctrl;
	word_t rd_mux;
	word_t rd_dat;

	// Ack blocks a second access on the next clock
	assign access = wb_req.cyc && wb_req.stb && !ack;
	assign is_ctrl = wb_req.adr == addr_t'(CTRL_ADDR);

	always_comb begin
		if (is_ctrl) begin
			rd_mux = {{PANEL_PAD{1'b0}}, panel};
		end else if (is_ts_addr(wb_req.adr)) begin
			rd_mux = ts_mem[ts_index(wb_req.adr)];
		end else if (is_ff_addr(wb_req.adr)) begin
			rd_mux = ff_rdata;		// Live storage contents
		end else begin
			rd_mux = '0;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			ack <= 1'b0;
			panel <= '0;
			for (int i = 0; i < TS_WORDS; i++) begin
				ts_mem[i] <= '0;
			end
		end else begin
			ack <= access;
			if (access && wb_req.we) begin
				if (is_ctrl) begin
					panel <= panel_t'(wb_req.dat[$bits(panel_t)-1:0]);
				end else if (is_ts_addr(wb_req.adr)) begin
					ts_mem[ts_index(wb_req.adr)] <= wb_req.dat;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			rd_dat <= rd_mux;	// Valid with ack
		end
	end

	assign wb_rsp = '{ack: ack, dat: rd_dat};

	// Flip-flop words live in storage and bus writes go there
	assign host_wr = '{
		en: access && wb_req.we && is_ff_addr(wb_req.adr),
		addr: wb_req.adr,
		dat: wb_req.dat
	};

	// Machine side read port
	assign ts_word = is_ts_addr(ts_addr) ? ts_mem[ts_index(ts_addr)] : '0;

	a_ack_with_req: assert property (
		@(posedge clk) disable iff (!reset)
		wb_rsp.ack |-> wb_req.cyc && wb_req.stb
	);

endmodule

//--- src/ww_storage.sv
`timescale 1ns/100ps

module ww_storage import ww_pkg::*; (
	input logic clk,
	input logic reset,
	input ctl_t ctl,
	input addr_t pc,
	input instr_t instr,
	input word_t ac,
	input host_wr_t host_wr,
	input addr_t host_addr,
	output word_t ff_rdata,
	output addr_t ts_addr,
	input word_t ts_word,
	output word_t st_word
);

	word_t ff_mem [FF_WORDS];	// Flip-flop storage
	addr_t st_addr;
	logic st_is_ff;
	logic [FF_IDX_W-1:0] st_idx;
	logic host_hit;

	// PC addresses storage during fetch and the instruction after
	assign st_addr = ctl.addr_sel_pc ? pc : instr.addr;
	assign st_is_ff = is_ff_addr(st_addr);
	assign st_idx = ff_index(st_addr);

	assign ts_addr = st_addr;
	assign st_word = st_is_ff ? ff_mem[st_idx] : ts_word;

	// Bus side read port
	assign ff_rdata = is_ff_addr(host_addr) ? ff_mem[ff_index(host_addr)] : '0;

	assign host_hit = host_wr.en && (host_wr.addr == st_addr);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < FF_WORDS; i++) begin
				ff_mem[i] <= '0;
			end
		end else begin
			if (ctl.st_write && st_is_ff) begin
				ff_mem[st_idx] <= ac;		// ts store
			end
			if (host_wr.en) begin
				ff_mem[ff_index(host_wr.addr)] <= host_wr.dat;	// Bus write wins
			end
		end
	end

	// Stores land only in flip-flop words
	a_store_lands: assert property (
		@(posedge clk) disable iff (!reset)
		ctl.st_write && st_is_ff && !host_hit |=> ff_mem[$past(st_idx)] == $past(ac)
	);

endmodule

//--- src/ww_control.sv
`timescale 1ns/100ps

module ww_control import ww_pkg::*; (
	input logic clk,
	input logic reset,
	input panel_t panel,
	input instr_t instr,
	input logic ac_neg,
	output ctl_t ctl,
	output logic running
);

	logic [DIV_W-1:0] div_cnt;	// Clock divider inside a time pulse
	tp_e tp;			// Time pulse distributor
	logic run_q;
	logic start;
	logic strobe;
	logic arith_op;

	assign start = panel.run && !run_q;

	// One-cycle time pulse, cut off as soon as run drops
	assign strobe = running && panel.run && (div_cnt == DIV_W'(TP_DIV - 1));

	assign arith_op = (instr.op == OP_CA) || (instr.op == OP_AD) || (instr.op == OP_SU);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			run_q <= 1'b0;
			running <= 1'b0;
			div_cnt <= '0;
			tp <= TP1;
		end else begin
			run_q <= panel.run;
			if (start) begin
				running <= 1'b1;
				div_cnt <= '0;
				tp <= TP1;
			end else if (!panel.run) begin
				running <= 1'b0;	// Abandon the instruction
			end else if (running) begin
				if (strobe) begin
					div_cnt <= '0;
					tp <= tp_e'(tp + 3'd1);	// TP8 wraps to TP1
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
			end
		end
	end

	// Operation timing matrix
	always_comb begin
		ctl = '0;
		ctl.addr_sel_pc = tp inside {TP1, TP2, TP3, TP4};
		if (strobe) begin
			case (tp)
				TP2: ctl.pr_load = 1'b1;
				TP3: ctl.pc_inc = 1'b1;
				TP6: begin
					ctl.ar_load = arith_op;
					ctl.ac_clear = instr.op == OP_CA;
				end
				TP7: begin
					ctl.ac_add = (instr.op == OP_CA) || (instr.op == OP_AD);
					ctl.ac_sub = instr.op == OP_SU;
					ctl.st_write = instr.op == OP_TS;
					// cp only on a negative AC
					ctl.jump = (instr.op == OP_SP) || ((instr.op == OP_CP) && ac_neg);
				end
				default: ;
			endcase
		end
	end

	// Add or subtract, one at a time, one time pulse after AR was loaded
	a_add_sub: assert property (
		@(posedge clk) disable iff (!reset)
		(ctl.ac_add || ctl.ac_sub) |->
			!(ctl.ac_add && ctl.ac_sub) && $past(ctl.ar_load, TP_DIV)
	);

endmodule

//--- src/ww_program.sv
`timescale 1ns/100ps

module ww_program import ww_pkg::*; (
	input logic clk,
	input logic reset,
	input panel_t panel,
	input ctl_t ctl,
	input word_t st_word,
	output instr_t instr,
	output addr_t pc
);

	logic run_q;
	logic start;

	// Run going high loads the start address
	assign start = panel.run && !run_q;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			run_q <= 1'b0;
			pc <= '0;
		end else begin
			run_q <= panel.run;
			if (start) begin
				pc <= panel.start_pc;
			end else if (ctl.jump) begin
				pc <= instr.addr;	// sp, or cp taken
			end else if (ctl.pc_inc) begin
				pc <= pc + 1'b1;
			end
		end
	end

	// Program register, opcode and address fields together
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			instr <= '0;
		end else if (ctl.pr_load) begin
			instr <= instr_t'(st_word);
		end
	end

endmodule

//--- src/ww_arith.sv
`timescale 1ns/100ps

module ww_arith import ww_pkg::*; (
	input logic clk,
	input logic reset,
	input ctl_t ctl,
	input word_t st_word,
	output word_t ac,
	output logic ac_neg
);

	word_t ar;			// A-register
	word_t operand;
	logic [WORD_W:0] raw_sum;
	word_t oc_sum;

	// Subtract adds the complement
	assign operand = ctl.ac_sub ? ~ar : ar;
	assign raw_sum = {1'b0, ac} + {1'b0, operand};

	// End-around carry back into the LSB
	assign oc_sum = raw_sum[WORD_W-1:0] + word_t'(raw_sum[WORD_W]);

	assign ac_neg = ac[WORD_W-1];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			ar <= '0;
		end else if (ctl.ar_load) begin
			ar <= st_word;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			ac <= '0;
		end else if (ctl.ac_clear) begin
			ac <= '0;
		end else if (ctl.ac_add || ctl.ac_sub) begin
			ac <= oc_sum;
		end
	end

endmodule

//--- src/ww_top.sv
`timescale 1ns/100ps

module ww_top import ww_pkg::*; (
	input logic clk,
	input logic reset,
	input wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	output status_t status
);

	panel_t panel;
	host_wr_t host_wr;
	addr_t ts_addr;
	word_t ts_word;
	word_t ff_rdata;
	ctl_t ctl;
	instr_t instr;
	addr_t pc;
	word_t st_word;
	word_t ac;
	logic ac_neg;
	logic running;

	ww_switch_regs ww_switch_regs_i (
		.clk(clk),
		.reset(reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.panel(panel),
		.host_wr(host_wr),
		.ts_addr(ts_addr),
		.ts_word(ts_word),
		.ff_rdata(ff_rdata)
	);

	ww_storage ww_storage_i (
		.clk(clk),
		.reset(reset),
		.ctl(ctl),
		.pc(pc),
		.instr(instr),
		.ac(ac),
		.host_wr(host_wr),
		.host_addr(wb_req.adr),		// Bus reads of flip-flop words
		.ff_rdata(ff_rdata),
		.ts_addr(ts_addr),
		.ts_word(ts_word),
		.st_word(st_word)
	);

	ww_control ww_control_i (
		.clk(clk),
		.reset(reset),
		.panel(panel),
		.instr(instr),
		.ac_neg(ac_neg),
		.ctl(ctl),
		.running(running)
	);

	ww_program ww_program_i (
		.clk(clk),
		.reset(reset),
		.panel(panel),
		.ctl(ctl),
		.st_word(st_word),
		.instr(instr),
		.pc(pc)
	);

	ww_arith ww_arith_i (
		.clk(clk),
		.reset(reset),
		.ctl(ctl),
		.st_word(st_word),
		.ac(ac),
		.ac_neg(ac_neg)
	);

	assign status = '{running: running, pc: pc, ac: ac};

endmodule

//--- test/ww_tb_clock.sv
`timescale 1ns/100ps

module ww_tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;		// 40 ns period
	end

	initial begin
		reset = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b1;			// Released after 4 cycles
	end

endmodule

//--- test/ww_tb.sv
`timescale 1ns/100ps

module ww_tb import ww_pkg::*; ();

	localparam int WB_TIMEOUT = 16;
	localparam int RUN_TIMEOUT = 2000;
	localparam int RESET_TIMEOUT = 20;
	localparam int STOP_WINDOW = 64;
	localparam addr_t PROG_BASE = addr_t'(TS_BASE);	// Programs start at 3745

	logic clk;
	logic reset;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	status_t status;
	int value_errors;
	int timeouts;
	logic [31:0] rng;
	word_t prog [TS_WORDS];		// Image of the toggle-switch words

	ww_tb_clock ww_tb_clock_i (
		.clk(clk),
		.reset(reset)
	);

	ww_top ww_top_i (
		.clk(clk),
		.reset(reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.status(status)
	);

	function automatic word_t next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng[15:0];
	endfunction

	// One's-complement sum, a carry out of the sign comes back in at the LSB
	function automatic word_t ones_add(word_t a, word_t b);
		logic [WORD_W:0] s;
		s = {1'b0, a} + {1'b0, b};
		if (s[WORD_W]) begin
			return s[WORD_W-1:0] + 16'd1;
		end
		return s[WORD_W-1:0];
	endfunction

	function automatic word_t op_word(opcode_e op, addr_t a);
		instr_t i;
		i.op = op;
		i.addr = a;
		return word_t'(i);
	endfunction

	function automatic word_t panel_word(logic run, addr_t start);
		panel_t p;
		p.run = run;
		p.start_pc = start;
		return word_t'(p);
	endfunction

	task automatic compare_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			value_errors++;
			$display("FAIL time=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic compare_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp) begin
			value_errors++;
			$display("FAIL time=%0t %s expected %o actual %o", $time, name, exp, act);
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			value_errors++;
			$display("FAIL time=%0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic wb_cycle(input logic we, input addr_t adr, input word_t dat,
			output word_t rdat);
		int n;
		n = 0;
		rdat = '0;
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		do begin
			@(posedge clk);
			n++;
		end while (!wb_rsp.ack && n < WB_TIMEOUT);
		if (wb_rsp.ack) begin
			rdat = wb_rsp.dat;
		end else begin
			timeouts++;
			$display("Timeout: no ack for the bus access at address %o", adr);
		end
		wb_req <= '0;
		@(posedge clk);
		compare_bit("wb_rsp.ack", 1'b0, wb_rsp.ack);	// Exactly one ack
	endtask

	task automatic wb_write(input addr_t adr, input word_t dat);
		word_t unused;
		wb_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input addr_t adr, output word_t dat);
		wb_cycle(1'b0, adr, '0, dat);
	endtask

	task automatic clear_program();
		for (int i = 0; i < TS_WORDS; i++) begin
			prog[i] = '0;
		end
	endtask

	task automatic load_program();
		for (int i = 0; i < TS_WORDS; i++) begin
			wb_write(addr_t'(TS_BASE + i), prog[i]);
		end
	endtask

	task automatic start_run(input addr_t start);
		wb_write(addr_t'(CTRL_ADDR), panel_word(1'b1, start));
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (!reset && n < RESET_TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (!reset) begin
			timeouts++;
			$display("Timeout: reset was never released");
		end
	endtask

	task automatic wait_pc(input addr_t target);
		int n;
		n = 0;
		while (status.pc !== target && n < RUN_TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (status.pc !== target) begin
			timeouts++;
			$display("Timeout: the PC never reached %o", target);
		end
	endtask

	task automatic wait_running(input logic exp);
		int n;
		n = 0;
		while (status.running !== exp && n < RUN_TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (status.running !== exp) begin
			timeouts++;
			$display("Timeout: status.running never became %b", exp);
		end
	endtask

	// Halt fetched means the instruction before it is done
	task automatic run_until_pc(input addr_t halt);
		wait_pc(addr_t'(halt + 1));
		wait_pc(halt);
		wb_write(addr_t'(CTRL_ADDR), '0);
	endtask

	task automatic after_reset();
		word_t d;
		compare_bit("status.running", 1'b0, status.running);
		compare_addr("status.pc", '0, status.pc);
		compare_word("status.ac", '0, status.ac);
		wb_read(addr_t'(CTRL_ADDR), d);
		compare_word("ctrl register", '0, d);
	endtask

	task automatic bus_access();
		word_t ts_exp [4];
		word_t ff_exp [FF_WORDS];
		word_t d;
		for (int k = 0; k < 4; k++) begin
			ts_exp[k] = next_rand();
			wb_write(addr_t'(TS_BASE + 7 * k), ts_exp[k]);
		end
		for (int k = 0; k < FF_WORDS; k++) begin
			ff_exp[k] = next_rand();
			wb_write(addr_t'(FF_BASE + k), ff_exp[k]);
		end
		for (int k = 0; k < 4; k++) begin
			wb_read(addr_t'(TS_BASE + 7 * k), d);
			compare_word($sformatf("switch word %o", TS_BASE + 7 * k), ts_exp[k], d);
		end
		for (int k = 0; k < FF_WORDS; k++) begin
			wb_read(addr_t'(FF_BASE + k), d);
			compare_word($sformatf("storage word %o", FF_BASE + k), ff_exp[k], d);
		end
		wb_write(addr_t'(CTRL_ADDR), panel_word(1'b0, addr_t'('o1234)));
		wb_read(addr_t'(CTRL_ADDR), d);
		compare_word("ctrl register", panel_word(1'b0, addr_t'('o1234)), d);
		wb_write(addr_t'(CTRL_ADDR), '0);
		wb_write(addr_t'('o100), 16'hffff);	// Unmapped
		wb_read(addr_t'('o100), d);
		compare_word("unmapped word 100", '0, d);
	endtask

	task automatic arith_program();
		word_t x;
		word_t y;
		word_t z;
		word_t exp;
		for (int r = 0; r < 5; r++) begin
			x = next_rand();
			y = next_rand();
			z = next_rand();
			if (r == 0) begin
				x = 16'hfff0;	// ad carries out of the sign
				y = 16'h0020;
			end
			if (r == 1) begin
				x = 16'h8001;
				y = 16'h8002;
			end
			clear_program();
			prog[0] = op_word(OP_CA, addr_t'('o3760));
			prog[1] = op_word(OP_AD, addr_t'('o3761));
			prog[2] = op_word(OP_SU, addr_t'('o3762));
			prog[3] = op_word(OP_SP, addr_t'('o3750));	// Halt
			prog[11] = x;
			prog[12] = y;
			prog[13] = z;
			load_program();
			exp = ones_add(ones_add(ones_add('0, x), y), ~z);
			start_run(PROG_BASE);
			run_until_pc(addr_t'('o3750));
			compare_word("status.ac", exp, status.ac);
		end
	endtask

	task automatic store_program();
		word_t v;
		word_t w;
		word_t d;
		v = next_rand();
		w = next_rand();
		wb_write(addr_t'('o3742), '0);
		clear_program();
		prog[0] = op_word(OP_CA, addr_t'('o3760));
		prog[1] = op_word(OP_TS, addr_t'('o3742));
		prog[2] = op_word(OP_TS, addr_t'('o3761));	// Switch word stays
		prog[3] = op_word(OP_SP, addr_t'('o3750));
		prog[11] = v;
		prog[12] = w;
		load_program();
		start_run(PROG_BASE);
		run_until_pc(addr_t'('o3750));
		wb_read(addr_t'('o3742), d);
		compare_word("storage word 3742", v, d);
		wb_read(addr_t'('o3761), d);
		compare_word("switch word 3761", w, d);
	endtask

	task automatic branch_case(input word_t n, input logic taken);
		addr_t halt;
		word_t d;
		halt = taken ? addr_t'('o3753) : addr_t'('o3750);
		wb_write(addr_t'('o3740), '0);
		wb_write(addr_t'('o3741), '0);
		clear_program();
		prog[0] = op_word(OP_CA, addr_t'('o3760));
		prog[1] = op_word(OP_CP, addr_t'('o3752));
		prog[2] = op_word(OP_TS, addr_t'('o3740));	// Fall-through path
		prog[3] = op_word(OP_SP, addr_t'('o3750));
		prog[5] = op_word(OP_TS, addr_t'('o3741));	// Jump path
		prog[6] = op_word(OP_SP, addr_t'('o3753));
		prog[11] = n;
		load_program();
		start_run(PROG_BASE);
		run_until_pc(halt);
		compare_addr("status.pc", halt, status.pc);
		wb_read(addr_t'('o3740), d);
		compare_word("storage word 3740", taken ? '0 : n, d);
		wb_read(addr_t'('o3741), d);
		compare_word("storage word 3741", taken ? n : '0, d);
	endtask

	task automatic branch_program();
		branch_case(next_rand() | 16'h8000, 1'b1);
		branch_case((next_rand() & 16'h7fff) | 16'h0001, 1'b0);
	endtask

	task automatic stop_run();
		addr_t held;
		clear_program();
		for (int i = 0; i < 10; i++) begin
			prog[i] = op_word(OP_AD, addr_t'('o3760));
		end
		prog[10] = op_word(OP_SP, PROG_BASE);	// Endless loop
		prog[11] = 16'h0003;
		load_program();
		start_run(PROG_BASE);
		wait_running(1'b1);
		wait_pc(addr_t'('o3750));
		wb_write(addr_t'(CTRL_ADDR), '0);
		wait_running(1'b0);
		held = status.pc;
		for (int n = 0; n < STOP_WINDOW; n++) begin
			@(posedge clk);
			compare_addr("status.pc", held, status.pc);
		end
	endtask

	initial begin
		wb_req = '0;
		value_errors = 0;
		timeouts = 0;
		rng = 32'd13;
		wait_reset();
		after_reset();
		bus_access();
		arith_program();
		store_program();
		branch_program();
		stop_run();
		$display("Errors: %0d wrong values, %0d timeouts", value_errors, timeouts);
		if (value_errors == 0 && timeouts == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- compile.f
src/ww_pkg.sv
src/ww_switch_regs.sv
src/ww_storage.sv
src/ww_control.sv
src/ww_program.sv
src/ww_arith.sv
src/ww_top.sv
test/ww_tb_clock.sv
test/ww_tb.sv

//--- Bender.yml
package:
  name: ww_machine

sources:
  - src/ww_pkg.sv
  - src/ww_switch_regs.sv
  - src/ww_storage.sv
  - src/ww_control.sv
  - src/ww_program.sv
  - src/ww_arith.sv
  - src/ww_top.sv
  - target: test
    files:
      - test/ww_tb_clock.sv
      - test/ww_tb.sv
